//--- Bender.yml
package:
  name: roce_ctrl

sources:
  - design/net_pkg.sv
  - design/roce_pkg.sv
  - design/run_status.sv
  - design/session_param_decode.sv
  - design/qp_setup_sequencer.sv
  - design/roce_ctrl_top.sv
  - target: test
    files:
      - test/roce_ctrl_tb.sv

//--- design/net_pkg.sv
//////////////////////////////////////////////////////////////////////
// network side definitions
// ipv4, mac and board number types, default host addresses
// configuration record handed to the packet path
//////////////////////////////////////////////////////////////////////
package net_pkg;

  // ipv4 address, network byte order
  typedef logic [31:0] ipv4_addr_t;

  // mac address, least significant byte first
  typedef logic [47:0] mac_addr_t;

  // board index, offsets the mac address
  typedef logic [3:0] board_num_t;

  //////////////////////////////////////////////////////////////////////
  // reset values of the session addresses
  //////////////////////////////////////////////////////////////////////
  localparam ipv4_addr_t default_local_ip  = 32'hD1D4010B; // 11.1.212.209
  localparam ipv4_addr_t default_remote_ip = 32'hD2D4010B; // 11.1.212.210

  // configuration for the ip handler, encoder and arp server
  typedef struct packed {
    mac_addr_t  mac;          // board mac
    ipv4_addr_t local_ip;     // own address
    ipv4_addr_t subnet_mask;
    ipv4_addr_t gateway;      // local address, low byte forced to 1
  } net_cfg_t;

endpackage

//--- design/qp_setup_sequencer.sv
//////////////////////////////////////////////////////////////////////
// queue pair setup sequencer
// qp context and connection records after the start delay
// paced read / write / read tx metadata series in test mode
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module qp_setup_sequencer #(
  parameter int unsigned start_delay = 1000,
  parameter int unsigned op_interval = 250
) (
  input  logic                   net_clk,
  input  logic                   net_aresetn,
  input  logic                   ap_start,
  input  logic                   test_mode,
  input  roce_pkg::session_req_t session,
  input  net_pkg::ipv4_addr_t    remote_ip,
  output roce_pkg::qp_ctx_t      qp_ctx,
  output logic                   qp_ctx_valid,
  input  logic                   qp_ctx_ready,
  output roce_pkg::qp_conn_t     qp_conn,
  output logic                   qp_conn_valid,
  input  logic                   qp_conn_ready,
  output roce_pkg::tx_meta_t     tx_meta,
  output logic                   tx_meta_valid,
  input  logic                   tx_meta_ready
);

  typedef enum logic [2:0] {
    st_idle,
    st_qp,
    st_conn,
    st_meta_read,
    st_meta_write,
    st_meta_read_2,
    st_gap
  } seq_state_t;

  // gap cycles between a meta transfer and the next issue
  localparam int unsigned gap_load = (op_interval > 1) ? op_interval - 2 : 0;

  seq_state_t  state;
  seq_state_t  resume;     // meta step that follows the gap
  seq_state_t  next_meta;  // step after the current meta command
  logic [31:0] wait_cnt;   // start-held cycles in idle
  logic [31:0] gap_cnt;    // down counter in gap

  // tx metadata for one rdma command
  function automatic roce_pkg::tx_meta_t make_meta(roce_pkg::rdma_op_t op,
                                                   roce_pkg::session_req_t s);
    roce_pkg::tx_meta_t m;
    m.op          = op;
    m.local_qpn   = s.local_qpn[23:0];
    m.local_addr  = (op == roce_pkg::rdma_write) ? roce_pkg::write_buffer_addr : 48'h0;
    m.remote_addr = '0;
    m.length      = s.length;
    return m;
  endfunction

  assign next_meta = (state == st_meta_read) ? st_meta_write : st_meta_read_2;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      state         <= st_idle;
      resume        <= st_meta_write;
      wait_cnt      <= '0;
      gap_cnt       <= '0;
      qp_ctx_valid  <= 1'b0;
      qp_conn_valid <= 1'b0;
      tx_meta_valid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (!ap_start) begin
            wait_cnt <= '0;  // delay counts from a fresh start
          end else if (wait_cnt == 32'(start_delay - 1)) begin
            wait_cnt          <= '0;
            qp_ctx.state      <= roce_pkg::qp_state_ready_recv;
            qp_ctx.remote_qpn <= session.remote_qpn[23:0];
            qp_ctx.remote_psn <= session.remote_psn[23:0];
            qp_ctx.local_psn  <= session.local_psn[23:0];
            qp_ctx.r_key      <= '0;
            qp_ctx.vaddr      <= session.vaddr[47:0];
            qp_ctx_valid      <= 1'b1;
            state             <= st_qp;
          end else begin
            wait_cnt <= wait_cnt + 32'd1;
          end
        end
        st_qp: if (qp_ctx_ready) begin  // valid is high here
          qp_ctx_valid       <= 1'b0;
          qp_conn.local_qpn  <= session.local_qpn[15:0];
          qp_conn.remote_qpn <= session.remote_qpn[23:0];
          qp_conn.remote_ip  <= remote_ip;  // already network order
          qp_conn.remote_udp <= session.remote_udp[15:0];
          qp_conn_valid      <= 1'b1;
          state              <= st_conn;
        end
        st_conn: if (qp_conn_ready) begin
          qp_conn_valid <= 1'b0;
          if (test_mode) begin
            tx_meta       <= make_meta(roce_pkg::rdma_read, session);
            tx_meta_valid <= 1'b1;
            state         <= st_meta_read;
          end else begin
            state <= st_idle;  // plain setup, no commands
          end
        end
        st_meta_read, st_meta_write: if (tx_meta_ready) begin
          if (op_interval > 1) begin
            tx_meta_valid <= 1'b0;
            gap_cnt       <= 32'(gap_load);
            resume        <= next_meta;
            state         <= st_gap;
          end else begin  // back to back, valid stays up
            tx_meta <= make_meta((next_meta == st_meta_write) ? roce_pkg::rdma_write
                                                              : roce_pkg::rdma_read, session);
            state   <= next_meta;
          end
        end
        st_meta_read_2: if (tx_meta_ready) begin
          tx_meta_valid <= 1'b0;
          state         <= st_idle;  // sequence end
        end
        st_gap: begin
          if (gap_cnt == '0) begin
            tx_meta <= make_meta((resume == st_meta_write) ? roce_pkg::rdma_write
                                                           : roce_pkg::rdma_read, session);
            tx_meta_valid <= 1'b1;
            state         <= resume;
          end else begin
            gap_cnt <= gap_cnt - 32'd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stream rule, record held until taken
  //////////////////////////////////////////////////////////////////////
  property p_hold(logic vld, logic rdy, logic [154:0] rec);
    @(posedge net_clk) disable iff (!net_aresetn)
      vld && !rdy |=> vld && $stable(rec);
  endproperty

  a_qp_ctx_hold:  assert property (p_hold(qp_ctx_valid, qp_ctx_ready, 155'(qp_ctx)));
  a_qp_conn_hold: assert property (p_hold(qp_conn_valid, qp_conn_ready, 155'(qp_conn)));
  a_tx_meta_hold: assert property (p_hold(tx_meta_valid, tx_meta_ready, tx_meta));

endmodule

//--- design/roce_ctrl_top.sv
//////////////////////////////////////////////////////////////////////
// roce session control top level
// run status, session decode and qp setup sequencer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module roce_ctrl_top #(
  parameter int unsigned         start_delay = 1000,
  parameter int unsigned         op_interval = 250,
  parameter int unsigned         run_limit   = 1000000,
  parameter net_pkg::mac_addr_t  mac_base    = 48'hE59D02350A00,
  parameter net_pkg::ipv4_addr_t subnet_mask = 32'h00FFFFFF
) (
  input  logic                   net_clk,
  input  logic                   net_aresetn,
  input  logic                   ap_start,
  input  roce_pkg::session_req_t session,
  output logic                   ap_idle,
  output logic                   ap_done,
  output logic                   ap_ready,
  output net_pkg::net_cfg_t      net_cfg,
  output roce_pkg::qp_ctx_t      qp_ctx,
  output logic                   qp_ctx_valid,
  input  logic                   qp_ctx_ready,
  output roce_pkg::qp_conn_t     qp_conn,
  output logic                   qp_conn_valid,
  input  logic                   qp_conn_ready,
  output roce_pkg::tx_meta_t     tx_meta,
  output logic                   tx_meta_valid,
  input  logic                   tx_meta_ready
);

  logic                start_pulse;  // rising edge of ap_start
  net_pkg::ipv4_addr_t remote_ip;    // swapped remote address
  logic                test_mode;    // r_key bit 0, latched

  run_status #(
    .run_limit (run_limit)
  ) u_run_status (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .ap_start    (ap_start),
    .start_pulse (start_pulse),
    .ap_idle     (ap_idle),
    .ap_done     (ap_done),
    .ap_ready    (ap_ready)
  );

  session_param_decode #(
    .mac_base    (mac_base),
    .subnet_mask (subnet_mask)
  ) u_decode (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .start_pulse (start_pulse),
    .session     (session),
    .remote_ip   (remote_ip),
    .test_mode   (test_mode),
    .net_cfg     (net_cfg)
  );

  qp_setup_sequencer #(
    .start_delay (start_delay),
    .op_interval (op_interval)
  ) u_sequencer (
    .net_clk       (net_clk),
    .net_aresetn   (net_aresetn),
    .ap_start      (ap_start),
    .test_mode     (test_mode),
    .session       (session),
    .remote_ip     (remote_ip),
    .qp_ctx        (qp_ctx),
    .qp_ctx_valid  (qp_ctx_valid),
    .qp_ctx_ready  (qp_ctx_ready),
    .qp_conn       (qp_conn),
    .qp_conn_valid (qp_conn_valid),
    .qp_conn_ready (qp_conn_ready),
    .tx_meta       (tx_meta),
    .tx_meta_valid (tx_meta_valid),
    .tx_meta_ready (tx_meta_ready)
  );

endmodule

//--- design/roce_pkg.sv
//////////////////////////////////////////////////////////////////////
// roce control definitions
// host session inputs, rdma opcodes, qp state code
// qp context, qp connection and tx metadata records
//////////////////////////////////////////////////////////////////////
package roce_pkg;

  // host inputs as written by the kernel driver
  typedef struct packed {
    logic [31:0] remote_psn;
    logic [31:0] local_psn;
    logic [31:0] remote_qpn;
    logic [31:0] local_qpn;
    logic [31:0] remote_ip;   // host byte order
    logic [31:0] local_ip;    // host byte order
    logic [31:0] remote_udp;
    logic [63:0] vaddr;       // only 48 bits reach the qp record
    logic [31:0] r_key;       // bit 0 selects test mode
    logic [31:0] op;
    logic [31:0] length;
  } session_req_t;

  typedef enum logic [2:0] {
    rdma_read  = 3'd0,
    rdma_write = 3'd1
  } rdma_op_t;

  localparam logic [2:0] qp_state_ready_recv = 3'd2;

  //////////////////////////////////////////////////////////////////////
  // records, first field is the msb end
  //////////////////////////////////////////////////////////////////////

  // 139 bits, state sits in [2:0]
  typedef struct packed {
    logic [47:0] vaddr;
    logic [15:0] r_key;       // always zero
    logic [23:0] local_psn;
    logic [23:0] remote_psn;
    logic [23:0] remote_qpn;
    logic [2:0]  state;
  } qp_ctx_t;

  // 88 bits, local qpn in [15:0]
  typedef struct packed {
    logic [15:0] remote_udp;
    logic [31:0] remote_ip;   // network byte order
    logic [23:0] remote_qpn;
    logic [15:0] local_qpn;
  } qp_conn_t;

  // 155 bits, opcode in [2:0]
  typedef struct packed {
    logic [31:0] length;
    logic [47:0] remote_addr;
    logic [47:0] local_addr;
    logic [23:0] local_qpn;
    rdma_op_t    op;
  } tx_meta_t;

  // local buffer used by the write command
  localparam logic [47:0] write_buffer_addr = 48'h000000000010;

endpackage

//--- design/run_status.sv
//////////////////////////////////////////////////////////////////////
// kernel run status
// start edge detect, run timer, idle / done / ready handshake
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module run_status #(
  parameter int unsigned run_limit = 1000000
) (
  input  logic net_clk,
  input  logic net_aresetn,
  input  logic ap_start,
  output logic start_pulse,
  output logic ap_idle,
  output logic ap_done,
  output logic ap_ready
);

  logic        start_r;   // ap_start last cycle
  logic [31:0] run_cnt;   // start-held cycles since reset or last done
  logic        done_hit;  // this cycle is the run_limit-th one

  assign start_pulse = ap_start & ~start_r;
  assign done_hit    = ap_start && (run_cnt == 32'(run_limit - 1));

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      start_r <= 1'b0;
      run_cnt <= '0;
      ap_done <= 1'b0;
      ap_idle <= 1'b1;
    end else begin
      start_r <= ap_start;
      ap_done <= done_hit;  // one cycle pulse
      if (done_hit) begin
        run_cnt <= '0;
      end else if (ap_start) begin
        run_cnt <= run_cnt + 32'd1;
      end
      // done wins over a start edge in the same cycle
      if (done_hit) begin
        ap_idle <= 1'b1;
      end else if (start_pulse) begin
        ap_idle <= 1'b0;
      end
    end
  end

  assign ap_ready = ap_done; // no pipelining

  a_done_single: assert property (
    @(posedge net_clk) disable iff (!net_aresetn) ap_done |=> !ap_done
  );

endmodule

//--- design/session_param_decode.sv
//////////////////////////////////////////////////////////////////////
// session parameter decode
// address capture on the start edge, byte swap to network order
// mac, subnet and gateway derivation
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module session_param_decode #(
  parameter net_pkg::mac_addr_t  mac_base    = 48'hE59D02350A00, // 00:0a:35:02:9d:e5
  parameter net_pkg::ipv4_addr_t subnet_mask = 32'h00FFFFFF
) (
  input  logic                   net_clk,
  input  logic                   net_aresetn,
  input  logic                   start_pulse,
  input  roce_pkg::session_req_t session,
  output net_pkg::ipv4_addr_t    remote_ip,
  output logic                   test_mode,
  output net_pkg::net_cfg_t      net_cfg
);

  net_pkg::ipv4_addr_t local_ip;
  net_pkg::board_num_t board_num;

  //////////////////////////////////////////////////////////////////////
  // capture stage
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      local_ip  <= net_pkg::default_local_ip;
      remote_ip <= net_pkg::default_remote_ip;
      board_num <= '0;
      test_mode <= 1'b0;
    end else if (start_pulse) begin
      local_ip  <= {<<8{session.local_ip}};   // host to network order
      remote_ip <= {<<8{session.remote_ip}};
      // r_key bit 0 doubles as board number and test select
      board_num <= net_pkg::board_num_t'(session.r_key[0]);
      test_mode <= session.r_key[0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // derived config, one cycle behind the capture
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      net_cfg <= '0;
    end else begin
      net_cfg.mac         <= {mac_base[47:44], mac_base[43:40] + board_num, mac_base[39:0]};
      net_cfg.local_ip    <= local_ip;
      net_cfg.subnet_mask <= subnet_mask;
      net_cfg.gateway     <= {local_ip[31:8], 8'h01}; // low byte set to 1
    end
  end

endmodule

//--- roce_ctrl_top.f
design/net_pkg.sv
design/roce_pkg.sv
design/run_status.sv
design/session_param_decode.sv
design/qp_setup_sequencer.sv
design/roce_ctrl_top.sv
test/roce_ctrl_tb.sv

//--- test/roce_ctrl_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the roce session control top level
// session table, lfsr ready back-pressure, stream and run status monitor
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module roce_ctrl_tb;

  localparam int unsigned         start_delay = 8;
  localparam int unsigned         op_interval = 6;
  localparam int unsigned         run_limit   = 200;
  localparam net_pkg::mac_addr_t  mac_base    = 48'hE59D02350A00;
  localparam net_pkg::ipv4_addr_t subnet_mask = 32'h00FFFFFF;
  localparam int                  num_rows    = 4;
  // rows plus one run timer phase
  localparam int timeout_cycles = num_rows * (start_delay + 4 * op_interval + 100) + run_limit;

  typedef struct {
    roce_pkg::session_req_t sess;
    net_pkg::ipv4_addr_t    lip_net;  // expected swapped local ip
    net_pkg::ipv4_addr_t    rip_net;  // expected swapped remote ip
    net_pkg::mac_addr_t     mac;      // base plus board number
    net_pkg::ipv4_addr_t    gw;
  } row_t;

  logic net_clk = 1'b0;
  logic net_aresetn, ap_start;
  logic ap_idle, ap_done, ap_ready;
  logic qp_ctx_valid, qp_ctx_ready, qp_conn_valid, qp_conn_ready;
  logic tx_meta_valid, tx_meta_ready;
  roce_pkg::session_req_t session;
  net_pkg::net_cfg_t      net_cfg, exp_cfg;
  roce_pkg::qp_ctx_t      qp_ctx, exp_qp, qp_prev;
  roce_pkg::qp_conn_t     qp_conn, exp_conn, conn_prev;
  roce_pkg::tx_meta_t     tx_meta, exp_meta, meta_prev;

  row_t        rows [num_rows];
  int          cur, meta_due, err0, done_base;
  int          n_checks, n_errors, n_qp, n_conn, n_meta, n_done;
  int          held_cnt, cycle, last_meta;
  logic        done_exp, idle_exp, start_prev, hit;
  logic        qp_hold, conn_hold, meta_hold;
  logic [31:0] lfsr = 32'h8a2c;

  roce_ctrl_top #(
    .start_delay (start_delay),
    .op_interval (op_interval),
    .run_limit   (run_limit),
    .mac_base    (mac_base),
    .subnet_mask (subnet_mask)
  ) uut (.*);

  always #5 net_clk = ~net_clk;

  // galois step for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic check_value(input logic [159:0] got, input logic [159:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s, expected %0h, got %0h", $time, what, exp, got);
    end
  endtask

  task automatic set_row(input int i, input logic [31:0] rpsn, lpsn, rqpn, lqpn, rip, lip,
                         input logic [31:0] udp, input logic [63:0] vaddr,
                         input logic [31:0] rkey, len, lip_net, rip_net,
                         input logic [47:0] mac, input logic [31:0] gw);
    rows[i].sess = '{remote_psn: rpsn, local_psn: lpsn, remote_qpn: rqpn, local_qpn: lqpn,
                     remote_ip: rip, local_ip: lip, remote_udp: udp, vaddr: vaddr,
                     r_key: rkey, op: 32'd0, length: len};
    rows[i].lip_net = lip_net;
    rows[i].rip_net = rip_net;
    rows[i].mac     = mac;
    rows[i].gw      = gw;
  endtask

  // expected records for row i cut to the record field widths
  task automatic set_expect(input int i);
    cur                 = i;
    exp_qp.state        = 3'd2;  // ready to receive
    exp_qp.remote_qpn   = rows[i].sess.remote_qpn[23:0];
    exp_qp.remote_psn   = rows[i].sess.remote_psn[23:0];
    exp_qp.local_psn    = rows[i].sess.local_psn[23:0];
    exp_qp.r_key        = '0;
    exp_qp.vaddr        = rows[i].sess.vaddr[47:0];
    exp_conn.local_qpn  = rows[i].sess.local_qpn[15:0];
    exp_conn.remote_qpn = rows[i].sess.remote_qpn[23:0];
    exp_conn.remote_ip  = rows[i].rip_net;
    exp_conn.remote_udp = rows[i].sess.remote_udp[15:0];
    exp_cfg             = '{mac: rows[i].mac, local_ip: rows[i].lip_net,
                            subnet_mask: subnet_mask, gateway: rows[i].gw};
    meta_due            = rows[i].sess.r_key[0] ? 3 : 0;
    n_qp                = 0;
    n_conn              = 0;
    n_meta              = 0;
  endtask

  // start one session, collect its transfers and drop start for 20 cycles
  task automatic run_row(input int i);
    err0 = n_errors;
    set_expect(i);
    session  = rows[i].sess;
    ap_start = 1'b1;
    repeat (2) @(posedge net_clk);
    @(negedge net_clk);
    check_value(net_cfg, exp_cfg, "net_cfg two cycles after start edge");
    while (n_conn < 1 || n_meta < meta_due) @(negedge net_clk);
    ap_start = 1'b0;
    repeat (20) @(negedge net_clk);
    check_value(n_qp, 1, "qp_ctx transfer count");
    check_value(n_conn, 1, "qp_conn transfer count");
    check_value(n_meta, meta_due, "tx_meta transfer count");
    $display("row %0d %s: %0d errors", i, meta_due ? "test mode" : "setup only", n_errors - err0);
  endtask

  ////////////////////////////////////////////////////////////////////
  // ready back-pressure with one lfsr step per bit
  ////////////////////////////////////////////////////////////////////
  always @(negedge net_clk) begin
    lfsr          = lfsr_next(lfsr);
    qp_ctx_ready  = lfsr[0];
    lfsr          = lfsr_next(lfsr);
    qp_conn_ready = lfsr[0];
    lfsr          = lfsr_next(lfsr);
    tx_meta_ready = lfsr[0];
  end

  ////////////////////////////////////////////////////////////////////
  // run status model and stream checks
  ////////////////////////////////////////////////////////////////////
  always @(posedge net_clk) begin
    if (!net_aresetn) begin
      held_cnt   = 0;
      done_exp   = 1'b0;
      idle_exp   = 1'b1;  // idle out of reset
      start_prev = 1'b0;
      qp_hold    = 1'b0;
      conn_hold  = 1'b0;
      meta_hold  = 1'b0;
    end else begin
      check_value(ap_done, done_exp, "ap_done");
      check_value(ap_ready, done_exp, "ap_ready");
      check_value(ap_idle, idle_exp, "ap_idle");
      if (ap_done) n_done++;
      hit = ap_start && (held_cnt == run_limit - 1);
      if (hit) begin
        held_cnt = 0;
        idle_exp = 1'b1;  // done wins over an edge
      end else begin
        if (ap_start) held_cnt++;
        if (ap_start && !start_prev) idle_exp = 1'b0;
      end
      done_exp   = hit;
      start_prev = ap_start;
      // held records must not move
      if (qp_hold) begin
        check_value(qp_ctx_valid, 1, "qp_ctx valid dropped");
        check_value(qp_ctx, qp_prev, "qp_ctx changed while stalled");
      end
      if (conn_hold) begin
        check_value(qp_conn_valid, 1, "qp_conn valid dropped");
        check_value(qp_conn, conn_prev, "qp_conn changed while stalled");
      end
      if (meta_hold) begin
        check_value(tx_meta_valid, 1, "tx_meta valid dropped");
        check_value(tx_meta, meta_prev, "tx_meta changed while stalled");
      end
      qp_hold   = qp_ctx_valid && !qp_ctx_ready;
      conn_hold = qp_conn_valid && !qp_conn_ready;
      meta_hold = tx_meta_valid && !tx_meta_ready;
      qp_prev   = qp_ctx;
      conn_prev = qp_conn;
      meta_prev = tx_meta;
      // transfers
      if (qp_ctx_valid && qp_ctx_ready) begin
        check_value(qp_ctx, exp_qp, "qp_ctx record");
        check_value(n_qp, n_conn, "qp_ctx before previous qp_conn");
        n_qp++;
      end
      if (qp_conn_valid && qp_conn_ready) begin
        check_value(qp_conn, exp_conn, "qp_conn record");
        check_value(n_qp, n_conn + 1, "qp_conn without qp_ctx");
        n_conn++;
      end
      if (tx_meta_valid && tx_meta_ready) begin
        exp_meta.op          = (n_meta == 1) ? roce_pkg::rdma_write : roce_pkg::rdma_read;
        exp_meta.local_qpn   = rows[cur].sess.local_qpn[23:0];
        exp_meta.local_addr  = (n_meta == 1) ? 48'h10 : 48'h0;  // write buffer
        exp_meta.remote_addr = '0;
        exp_meta.length      = rows[cur].sess.length;
        check_value(tx_meta, exp_meta, "tx_meta record");
        check_value(n_conn, n_qp, "tx_meta before qp_conn");
        if (n_meta > 0) check_value(cycle - last_meta >= op_interval, 1, "tx_meta spacing");
        last_meta = cycle;
        n_meta++;
      end
    end
  end

  always @(posedge net_clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    net_aresetn = 1'b0;
    ap_start = 1'b0;
    session = '0;
    qp_ctx_ready = 1'b0;
    qp_conn_ready = 1'b0;
    tx_meta_ready = 1'b0;
    cycle = 0;
    n_checks = 0;
    n_errors = 0;
    n_done = 0;
    last_meta = 0;
    set_row(0, 32'h00A1B2C3, 32'h00112233, 32'h00000011, 32'h00000010, 32'h0B01D4D2,
            32'h0B01D4D1, 32'h000012B7, 64'h0000000000001000, 32'h00000000, 32'h00000040,
            32'hD1D4010B, 32'hD2D4010B, 48'hE59D02350A00, 32'hD1D40101);
    set_row(1, 32'hFF123456, 32'h00654321, 32'hFF000123, 32'h00ABCDEF, 32'hC0A80106,
            32'hC0A80105, 32'hABCD12B7, 64'hFFFF123456789ABC, 32'h00001235, 32'h00010000,
            32'h0501A8C0, 32'h0601A8C0, 48'hE69D02350A00, 32'h0501A801);
    set_row(2, 32'h00000001, 32'h00FFFFFF, 32'h00000400, 32'h00000401, 32'h0A000002,
            32'h0A000001, 32'h00001234, 64'h00007FFFFFFFF000, 32'h00000002, 32'h00000100,
            32'h0100000A, 32'h0200000A, 48'hE59D02350A00, 32'h01000001);
    set_row(3, 32'h00C0FFEE, 32'h00BEEF00, 32'h00ABCDEF, 32'h00FEDCBA, 32'hAC100A1E,
            32'hAC100A14, 32'h000012B7, 64'h0000DEADBEEF0000, 32'hFFFF0001, 32'h00000020,
            32'h140A10AC, 32'h1E0A10AC, 48'hE69D02350A00, 32'h140A1001);
    set_expect(0);
    repeat (2) @(posedge net_clk);
    @(negedge net_clk);
    net_aresetn = 1'b1;
    check_value(net_cfg, '0, "net_cfg after reset");
    for (int i = 0; i < num_rows; i++) run_row(i);
    // hold start until the run timer fires
    set_expect(0);
    done_base = n_done;
    session   = rows[0].sess;
    ap_start  = 1'b1;
    while (n_done == done_base) @(negedge net_clk);
    ap_start = 1'b0;
    repeat (20) @(negedge net_clk);
    $display("run timer: %0d done pulses, %0d errors", n_done, n_errors);
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
